/* rtl/fwrisc_data_pkg.sv */
package fwrisc_data_pkg;

	localparam int DATA_WIDTH = 32;
	localparam int WIDE_WIDTH = 2 * DATA_WIDTH;
	localparam int REGADDR_WIDTH = 6;	// Bit 5 rides along unchanged
	localparam int COUNT_WIDTH = 6;

	// Iterations for one multiply or divide
	localparam int STEP_COUNT = DATA_WIDTH;

	typedef logic [DATA_WIDTH-1:0] data_t;
	typedef logic [WIDE_WIDTH-1:0] wide_t;	// Product, or remainder and quotient
	typedef logic [REGADDR_WIDTH-1:0] regaddr_t;
	typedef logic [COUNT_WIDTH-1:0] count_t;

endpackage

/* rtl/fwrisc_mds_op_pkg.sv */
package fwrisc_mds_op_pkg;

	// Operation codes as presented by decode
	typedef enum logic [3:0] {
		OP_SLL   = 4'd0,
		OP_SRL   = 4'd1,
		OP_SRA   = 4'd2,
		OP_MUL   = 4'd3,
		OP_MULH  = 4'd4,
		OP_MULHU = 4'd5,
		OP_DIV   = 4'd6,
		OP_DIVU  = 4'd7,
		OP_REM   = 4'd8,
		OP_REMU  = 4'd9
	} mds_op_t;

	localparam int OP_NUM_MDS = 10;

	// Engine mode chosen at issue
	typedef enum logic [1:0] {
		CLASS_SHIFT = 2'd0,
		CLASS_MUL   = 2'd1,
		CLASS_DIV   = 2'd2
	} mds_class_t;

endpackage

/* rtl/fwrisc_mds_issue.sv */
`timescale 1ns/1ps

module fwrisc_mds_issue import fwrisc_data_pkg::*, fwrisc_mds_op_pkg::*; (
	input  logic       clock,
	input  logic       reset,
	input  logic       decode_valid,
	input  logic       instr_complete,
	input  mds_op_t    op,
	input  data_t      op_a,
	input  data_t      op_b,
	input  regaddr_t   rd,
	output logic       start,
	output mds_class_t op_class,
	output logic       shift_right,
	output logic       shift_arith,
	output data_t      mag_a,
	output data_t      mag_b,
	output count_t     shamt,
	output mds_op_t    held_op,
	output regaddr_t   held_rd,
	output logic       negate,
	output logic       div_zero,
	output data_t      orig_a
);

	logic       busy;
	logic       accept;
	mds_class_t class_c;
	logic       right_c;
	logic       arith_c;
	logic       signed_c;	// Operands go through absolute value
	logic       negate_c;

	assign accept = decode_valid && !busy && !instr_complete;

	always_comb begin
		class_c = CLASS_SHIFT;
		right_c = 1'b0;
		arith_c = 1'b0;
		signed_c = 1'b0;
		negate_c = 1'b0;
		case (op)
			OP_SRL: right_c = 1'b1;
			OP_SRA: begin
				right_c = 1'b1;
				arith_c = 1'b1;
			end
			OP_MUL, OP_MULHU: class_c = CLASS_MUL;	// Low word is sign agnostic
			OP_MULH: begin
				class_c = CLASS_MUL;
				signed_c = 1'b1;
				negate_c = op_a[DATA_WIDTH-1] ^ op_b[DATA_WIDTH-1];
			end
			OP_DIVU, OP_REMU: class_c = CLASS_DIV;
			OP_DIV: begin
				class_c = CLASS_DIV;
				signed_c = 1'b1;
				negate_c = op_a[DATA_WIDTH-1] ^ op_b[DATA_WIDTH-1];
			end
			OP_REM: begin
				class_c = CLASS_DIV;
				signed_c = 1'b1;
				negate_c = op_a[DATA_WIDTH-1];	// Remainder follows the dividend
			end
			default: ;
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			busy <= 1'b0;
			start <= 1'b0;
		end else begin
			start <= accept;
			if (accept) begin
				busy <= 1'b1;
			end else if (instr_complete) begin
				busy <= 1'b0;
			end
		end
	end

	// Operation fields held for the whole run
	always_ff @(posedge clock) begin
		if (accept) begin
			op_class <= class_c;
			shift_right <= right_c;
			shift_arith <= arith_c;
			mag_a <= (signed_c && op_a[DATA_WIDTH-1]) ? data_t'(-op_a) : op_a;
			mag_b <= (signed_c && op_b[DATA_WIDTH-1]) ? data_t'(-op_b) : op_b;
			shamt <= count_t'(op_b[4:0]);
			held_op <= op;
			held_rd <= rd;
			negate <= negate_c;
			div_zero <= (class_c == CLASS_DIV) && (op_b == '0);
			orig_a <= op_a;
		end
	end

endmodule

/* rtl/fwrisc_mds_engine.sv */
`timescale 1ns/1ps

module fwrisc_mds_engine import fwrisc_data_pkg::*, fwrisc_mds_op_pkg::*; (
	input  logic       clock,
	input  logic       reset,
	input  logic       start,
	input  mds_class_t op_class,
	input  logic       shift_right,
	input  logic       shift_arith,
	input  data_t      mag_a,
	input  data_t      mag_b,
	input  count_t     shamt,
	output logic       done,
	output wide_t      result_wide
);

	typedef enum logic [2:0] {
		IDLE,
		SHIFT,
		MUL,
		DIV,
		FINISH
	} state_t;

	state_t state;
	count_t count;	// Steps still to run
	wide_t  acc;

	logic [DATA_WIDTH:0] mul_sum;
	logic [DATA_WIDTH:0] div_trial;
	logic                shift_fill;

	assign done = (state == FINISH);
	assign result_wide = acc;

	always_comb begin
		// Upper half accumulates, multiplier bit sits at the bottom
		mul_sum = {1'b0, acc[WIDE_WIDTH-1:DATA_WIDTH]} +
			(acc[0] ? {1'b0, mag_b} : '0);
		// Remainder with next dividend bit, minus divisor
		div_trial = acc[WIDE_WIDTH-1:DATA_WIDTH-1] - {1'b0, mag_b};
		shift_fill = shift_arith & acc[DATA_WIDTH-1];
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= IDLE;
			count <= '0;
		end else begin
			case (state)
				IDLE: begin
					if (start) begin
						case (op_class)
							CLASS_SHIFT: begin
								state <= (shamt == '0) ? FINISH : SHIFT;
								count <= shamt;
							end
							CLASS_MUL: begin
								state <= MUL;
								count <= count_t'(STEP_COUNT);
							end
							default: begin
								state <= DIV;
								count <= count_t'(STEP_COUNT);
							end
						endcase
					end
				end
				SHIFT, MUL, DIV: begin
					count <= count - count_t'(1);
					if (count == count_t'(1)) begin
						state <= FINISH;	// Last step runs this cycle
					end
				end
				FINISH: state <= IDLE;
				default: state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		case (state)
			IDLE: begin
				if (start) begin
					acc <= {{DATA_WIDTH{1'b0}}, mag_a};	// Value, multiplier or dividend
				end
			end
			SHIFT: begin
				if (shift_right) begin
					acc[DATA_WIDTH-1:0] <= {shift_fill, acc[DATA_WIDTH-1:1]};
				end else begin
					acc[DATA_WIDTH-1:0] <= {acc[DATA_WIDTH-2:0], 1'b0};
				end
			end
			MUL: acc <= {mul_sum, acc[DATA_WIDTH-1:1]};
			DIV: begin
				if (!div_trial[DATA_WIDTH]) begin
					// Subtract fits, quotient bit is one
					acc <= {div_trial[DATA_WIDTH-1:0], acc[DATA_WIDTH-2:0], 1'b1};
				end else begin
					acc <= {acc[WIDE_WIDTH-2:0], 1'b0};	// Restore by not subtracting
				end
			end
			default: ;
		endcase
	end

endmodule

/* rtl/fwrisc_mds_writeback.sv */
`timescale 1ns/1ps

module fwrisc_mds_writeback import fwrisc_data_pkg::*, fwrisc_mds_op_pkg::*; (
	input  logic     clock,
	input  logic     reset,
	input  logic     done,
	input  wide_t    result_wide,
	input  mds_op_t  op,
	input  regaddr_t rd,
	input  logic     negate,
	input  logic     div_zero,
	input  data_t    orig_a,
	output logic     instr_complete,
	output logic     rd_write,
	output regaddr_t rd_addr,
	output data_t    rd_wdata
);

	wide_t prod_fix;
	data_t quo_fix;
	data_t rem_fix;
	data_t wb_word;

	always_comb begin
		// Sign fixup, product as a whole and divide halves apart
		prod_fix = negate ? wide_t'(-result_wide) : result_wide;
		quo_fix = negate ? data_t'(-result_wide[DATA_WIDTH-1:0]) :
			result_wide[DATA_WIDTH-1:0];
		rem_fix = negate ? data_t'(-result_wide[WIDE_WIDTH-1:DATA_WIDTH]) :
			result_wide[WIDE_WIDTH-1:DATA_WIDTH];
		case (op)
			OP_MUL: wb_word = prod_fix[DATA_WIDTH-1:0];
			OP_MULH, OP_MULHU: wb_word = prod_fix[WIDE_WIDTH-1:DATA_WIDTH];
			OP_DIV, OP_DIVU: wb_word = div_zero ? '1 : quo_fix;
			OP_REM, OP_REMU: wb_word = div_zero ? orig_a : rem_fix;
			default: wb_word = result_wide[DATA_WIDTH-1:0];	// Shifts
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			instr_complete <= 1'b0;
			rd_write <= 1'b0;
		end else begin
			instr_complete <= done;
			rd_write <= done;
		end
	end

	always_ff @(posedge clock) begin
		if (done) begin
			rd_addr <= rd;
			rd_wdata <= wb_word;
		end
	end

endmodule

/* rtl/fwrisc_mds_exec.sv */
`timescale 1ns/1ps

module fwrisc_mds_exec import fwrisc_data_pkg::*, fwrisc_mds_op_pkg::*; (
	input  logic     clock,
	input  logic     reset,
	input  logic     decode_valid,
	input  mds_op_t  op,
	input  data_t    op_a,
	input  data_t    op_b,
	input  regaddr_t rd,
	output logic     instr_complete,
	output logic     rd_write,
	output regaddr_t rd_addr,
	output data_t    rd_wdata
);

	logic       start;
	mds_class_t op_class;
	logic       shift_right;
	logic       shift_arith;
	data_t      mag_a;
	data_t      mag_b;
	count_t     shamt;
	mds_op_t    held_op;
	regaddr_t   held_rd;
	logic       negate;
	logic       div_zero;
	data_t      orig_a;
	logic       done;
	wide_t      result_wide;

	fwrisc_mds_issue fwrisc_mds_issue_inst (
		.clock          (clock),
		.reset          (reset),
		.decode_valid   (decode_valid),
		.instr_complete (instr_complete),	// Frees issue for the next op
		.op             (op),
		.op_a           (op_a),
		.op_b           (op_b),
		.rd             (rd),
		.start          (start),
		.op_class       (op_class),
		.shift_right    (shift_right),
		.shift_arith    (shift_arith),
		.mag_a          (mag_a),
		.mag_b          (mag_b),
		.shamt          (shamt),
		.held_op        (held_op),
		.held_rd        (held_rd),
		.negate         (negate),
		.div_zero       (div_zero),
		.orig_a         (orig_a)
	);

	fwrisc_mds_engine fwrisc_mds_engine_inst (
		.clock       (clock),
		.reset       (reset),
		.start       (start),
		.op_class    (op_class),
		.shift_right (shift_right),
		.shift_arith (shift_arith),
		.mag_a       (mag_a),
		.mag_b       (mag_b),
		.shamt       (shamt),
		.done        (done),
		.result_wide (result_wide)
	);

	fwrisc_mds_writeback fwrisc_mds_writeback_inst (
		.clock          (clock),
		.reset          (reset),
		.done           (done),
		.result_wide    (result_wide),
		.op             (held_op),
		.rd             (held_rd),
		.negate         (negate),
		.div_zero       (div_zero),
		.orig_a         (orig_a),
		.instr_complete (instr_complete),
		.rd_write       (rd_write),
		.rd_addr        (rd_addr),
		.rd_wdata       (rd_wdata)
	);

endmodule

/* sim/fwrisc_mds_tb.sv */
`timescale 1ns/1ps

module fwrisc_mds_tb import fwrisc_data_pkg::*, fwrisc_mds_op_pkg::*;;

	localparam string STIM_FILE = "sim/fwrisc_mds_stim.txt";

	logic     clock;
	logic     reset;
	logic     decode_valid;
	mds_op_t  op;
	data_t    op_a;
	data_t    op_b;
	regaddr_t rd;
	logic     instr_complete;
	logic     rd_write;
	regaddr_t rd_addr;
	data_t    rd_wdata;

	mds_op_t  vec_op[$];
	data_t    vec_a[$];
	data_t    vec_b[$];
	regaddr_t vec_rd[$];
	data_t    vec_exp[$];

	int cycle_count = 0;
	int cycle_limit = 0;	// Set once the vectors are loaded
	int write_count = 0;

	fwrisc_mds_exec fwrisc_mds_exec_inst (
		.clock          (clock),
		.reset          (reset),
		.decode_valid   (decode_valid),
		.op             (op),
		.op_a           (op_a),
		.op_b           (op_b),
		.rd             (rd),
		.instr_complete (instr_complete),
		.rd_write       (rd_write),
		.rd_addr        (rd_addr),
		.rd_wdata       (rd_wdata)
	);

	always #10 clock = ~clock;

	task automatic fail_run(input string reason);
		$display("%s", reason);
		$display("Regression failed");
		$fatal(1, "Stopped at first error");
	endtask

	task automatic check_data(input string name, input data_t expected, input data_t actual);
		if (actual !== expected) begin
			fail_run($sformatf("Mismatch %s: expected 0x%h, got 0x%h", name, expected, actual));
		end
	endtask

	task automatic check_rd(input string name, input regaddr_t expected, input regaddr_t actual);
		if (actual !== expected) begin
			fail_run($sformatf("Mismatch %s: expected 0x%h, got 0x%h", name, expected, actual));
		end
	endtask

	task automatic check_bit(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			fail_run($sformatf("Mismatch %s: expected 0x%h, got 0x%h", name, expected, actual));
		end
	endtask

	task automatic check_count(input string name, input int expected, input int actual);
		if (actual != expected) begin
			fail_run($sformatf("Mismatch %s: expected 0x%h, got 0x%h", name, expected, actual));
		end
	endtask

	task automatic load_vectors;
		int          fd;
		int          n;
		int          line_no;
		string       line;
		logic [31:0] code_v;
		logic [31:0] a_v;
		logic [31:0] b_v;
		logic [31:0] rd_v;
		logic [31:0] exp_v;
		fd = $fopen(STIM_FILE, "r");
		if (fd == 0) begin
			fail_run($sformatf("Could not open stimulus file %s", STIM_FILE));
		end else begin
			line_no = 0;
			while ($fgets(line, fd) > 0) begin
				line_no++;
				if (line.len() > 0 && line[0] != "#") begin	// Skip column notes
					n = $sscanf(line, "%h %h %h %h %h", code_v, a_v, b_v, rd_v, exp_v);
					if (n == 5) begin
						if (code_v >= OP_NUM_MDS) begin
							fail_run($sformatf("Line %0d of the stimulus file has unknown operation code %0h",
								line_no, code_v));
						end else begin
							vec_op.push_back(mds_op_t'(code_v[3:0]));
							vec_a.push_back(a_v);
							vec_b.push_back(b_v);
							vec_rd.push_back(regaddr_t'(rd_v));
							vec_exp.push_back(exp_v);
						end
					end else if (n > 0) begin
						fail_run($sformatf("Line %0d of the stimulus file is incomplete", line_no));
					end
				end
			end
			$fclose(fd);
		end
	endtask

	// One decode handshake, held until the unit completes
	task automatic run_vector(input int idx);
		logic seen;
		@(negedge clock);
		decode_valid = 1'b1;
		op = vec_op[idx];
		op_a = vec_a[idx];
		op_b = vec_b[idx];
		rd = vec_rd[idx];
		seen = 1'b0;
		while (!seen) begin
			@(negedge clock);
			if (instr_complete === 1'b1) begin
				seen = 1'b1;
			end else begin
				check_bit("rd_write", 1'b0, rd_write);	// No write ahead of complete
			end
		end
		check_bit("rd_write", 1'b1, rd_write);
		check_rd($sformatf("rd_addr (vector %0d)", idx), vec_rd[idx], rd_addr);
		check_data($sformatf("rd_wdata (vector %0d)", idx), vec_exp[idx], rd_wdata);
		decode_valid = 1'b0;
	endtask

	task automatic idle_gap(input int cycles);
		repeat (cycles) begin
			@(negedge clock);
			check_bit("instr_complete", 1'b0, instr_complete);
			check_bit("rd_write", 1'b0, rd_write);
		end
	endtask

	always @(negedge clock) begin
		if (!reset && rd_write === 1'b1) begin
			write_count++;
		end
	end

	always @(posedge clock) begin
		cycle_count++;
		if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
			fail_run($sformatf("Timeout: the DUT did not finish all vectors within %0d cycles",
				cycle_limit));
		end
	end

	initial begin
		int idx;
		clock = 1'b0;
		reset = 1'b1;
		decode_valid = 1'b0;
		op = OP_SLL;
		op_a = '0;
		op_b = '0;
		rd = '0;
		void'($urandom(92));
		load_vectors();
		if (vec_op.size() == 0) begin
			fail_run("The stimulus file holds no vectors");
		end
		cycle_limit = vec_op.size() * 40 + 20;	// Longest op plus gap fits in 40
		repeat (5) begin
			@(posedge clock);
			@(negedge clock);
			check_bit("instr_complete", 1'b0, instr_complete);
			check_bit("rd_write", 1'b0, rd_write);
		end
		reset = 1'b0;
		for (idx = 0; idx < vec_op.size(); idx++) begin
			run_vector(idx);
			idle_gap($urandom_range(3, 0));
		end
		idle_gap(1);
		check_count("rd_write pulse count", vec_op.size(), write_count);
		$display("Regression passed");
		$finish;
	end

endmodule

/* compile.f */
rtl/fwrisc_data_pkg.sv
rtl/fwrisc_mds_op_pkg.sv
rtl/fwrisc_mds_issue.sv
rtl/fwrisc_mds_engine.sv
rtl/fwrisc_mds_writeback.sv
rtl/fwrisc_mds_exec.sv
sim/fwrisc_mds_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the execute unit testbench with Verilator and runs it from the project root
set -u

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --top-module fwrisc_mds_tb -f compile.f \
	--Mdir obj_dir -o fwrisc_mds_sim; then
	echo "Verilator build failed"
	exit 1
fi

output=$(./obj_dir/fwrisc_mds_sim 2>&1)
status=$?
echo "$output"

if [ "$status" -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -qx "Regression passed"; then
	exit 0
fi

echo "Pass message not found in simulation output"
exit 1

/* sim/fwrisc_mds_stim.txt */
# Columns: op code, op_a, op_b, rd, expected rd_wdata (all hex)
# Op codes: 0 SLL, 1 SRL, 2 SRA, 3 MUL, 4 MULH, 5 MULHU, 6 DIV, 7 DIVU, 8 REM, 9 REMU
0 12345678 00000000 01 12345678
0 80000001 00000001 02 00000002
0 00000003 ffffffff 03 80000000
1 80000000 00000021 24 40000000
1 f0000000 0000001f 05 00000001
2 80000010 00000001 26 c0000008
2 80000000 0000005f 07 ffffffff
2 deadbeef 00000020 09 deadbeef
3 fffffffd 00000005 2b fffffff1
3 80000000 80000000 13 00000000
4 fffffffd 00000005 0c ffffffff
4 00010000 00010000 0d 00000001
4 ffff0000 ffff0000 0e 00000001
4 00010000 ffff0000 0f ffffffff
4 80000000 80000000 10 40000000
5 80000000 80000000 31 40000000
5 ffffffff ffffffff 12 fffffffe
6 00000014 fffffffa 14 fffffffd
6 ffffffec fffffffa 15 00000003
6 ffffffec 00000006 16 fffffffd
6 00000064 00000007 36 0000000e
6 80000000 ffffffff 17 80000000
8 ffffffec 00000006 18 fffffffe
8 00000014 fffffffa 19 00000002
8 ffffffec fffffffa 1a fffffffe
8 80000000 ffffffff 1b 00000000
7 fffffffe 00000003 1c 55555554
9 fffffffe 00000003 1d 00000002
6 00000005 00000000 1e ffffffff
7 80000000 00000000 3f ffffffff
8 fffffff9 00000000 20 fffffff9
9 12345678 00000000 21 12345678
